// File: bench/decodeTb.sv
`timescale 1ns/10ps
`default_nettype none

module valueCheck #(
  parameter int    W    = 32,
  parameter string NAME = "signal"
) (
  input  logic         clk,
  input  logic         en,
  input  logic [W-1:0] actual,
  input  logic [W-1:0] expected,
  output int           errs
);
  int count = 0;

  assign errs = count;

  matchesModel: assert property (@(posedge clk) disable iff (!en) actual == expected)
    else begin
      count++;
      $display("FAIL time %0t %s got %h expected %h", $time, NAME,
               $sampled(actual), $sampled(expected));
    end

endmodule

module decodeTb;
  import rvPkg::*;

  localparam int resetVectors  = 32;
  localparam int writeVectors  = 48;
  localparam int decodeVectors = 16; // Per opcode
  localparam int stallVectors  = 12;
  localparam int vectorCount   = resetVectors + 2 * writeVectors + 9 * decodeVectors
                                 + stallVectors;

  logic        clk;
  logic        rstN;
  logic [31:0] instrF;
  logic [31:0] pcF;
  logic [31:0] pcPlus4F;
  logic        stallD;
  logic        flushD;
  logic        flushE;
  logic        regWriteW;
  logic [4:0]  rdW;
  logic [31:0] resultW;
  logic [31:0] rd1E;
  logic [31:0] rd2E;
  logic [31:0] immExtE;
  logic [31:0] pcE;
  logic [31:0] pcPlus4E;
  logic [4:0]  rs1E;
  logic [4:0]  rs2E;
  logic [4:0]  rdE;
  logic        regWriteE;
  logic        memWriteE;
  logic        aluSrcE;
  logic        branchE;
  logic        jumpE;
  logic        pcResE;
  logic [1:0]  resultSrcE;
  logic [1:0]  memSizeE;
  logic        memSignedE;
  aluCtrlE     aluControlE;

  logic [31:0] mRegs [32];    // Reference register file
  logic [31:0] mInstrD;
  logic [31:0] mPcD;
  logic [31:0] mPc4D;
  logic [14:0] expCtrl;       // Same layout as dutCtrl
  logic [14:0] dutCtrl;
  logic [31:0] expRd1;
  logic [31:0] expRd2;
  logic [31:0] expImm;
  logic [31:0] expPc;
  logic [31:0] expPc4;
  logic [4:0]  expRs1;
  logic [4:0]  expRs2;
  logic [4:0]  expRd;
  logic [31:0] pc;
  int          errs [18];
  int          resetErrs = 0;
  int          vectors = 0;
  int          seed = 32'h74ed9d0d;
  logic [6:0]  opList [9] = '{opR, opI, opLoad, opStore, opBranch, opJal, opJalr, opLui,
                              opAuipc};

  decodeTop u_decodeTop (.*);

  assign dutCtrl = {regWriteE, memWriteE, aluSrcE, branchE, jumpE, pcResE, resultSrcE,
                    memSizeE, memSignedE, aluControlE};

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [3:0] aluCodeOf(input logic [2:0] f3, input logic b30,
                                           input logic isReg);
    case (f3)
      3'b000:  return (isReg && b30) ? aluSub : aluAdd; // Only R-type subtracts
      3'b001:  return aluSll;
      3'b010:  return aluSlt;
      3'b011:  return aluSltu;
      3'b100:  return aluXor;
      3'b101:  return b30 ? aluSra : aluSrl;
      3'b110:  return aluOr;
      default: return aluAnd;
    endcase
  endfunction

  function automatic logic [14:0] controlsOf(input logic [31:0] ins);
    logic [5:0] flags; // regWrite memWrite aluSrc branch jump pcRes
    logic [1:0] res;
    logic [1:0] size;
    logic       sgn;
    logic [3:0] alu;
    flags = '0;
    res   = resAlu;
    size  = 2'b00;
    sgn   = 1'b0;
    alu   = aluAdd;
    case (ins[6:0])
      opR: begin
        flags = 6'b100000;
        alu   = aluCodeOf(ins[14:12], ins[30], 1'b1);
      end
      opI: begin
        flags = 6'b101000;
        alu   = aluCodeOf(ins[14:12], ins[30], 1'b0);
      end
      opLoad: begin
        flags = 6'b101000;
        res   = resMem;
        size  = ins[13:12];
        sgn   = !ins[14];
      end
      opStore: begin
        flags = 6'b011000;
        size  = ins[13:12];
      end
      opBranch: begin
        flags = 6'b000100;
        alu   = ins[14] ? (ins[13] ? aluSltu : aluSlt) : aluSub;
      end
      opJal: begin
        flags = 6'b100010;
        res   = resPc4;
      end
      opJalr: begin
        flags = 6'b101010;
        res   = resPc4;
      end
      opLui:   flags = 6'b101000;
      opAuipc: flags = 6'b101001;
      default: flags = 6'b000000;
    endcase
    return {flags, res, size, sgn, alu};
  endfunction

  // R-type has no immediate and falls to the I layout
  function automatic logic [31:0] signExtImm(input logic [31:0] ins);
    logic [31:0] s;
    s = {32{ins[31]}};
    case (ins[6:0])
      opStore:        return (s << 11) | {21'b0, ins[30:25], ins[11:7]};
      opBranch:       return (s << 12) | {20'b0, ins[7], ins[30:25], ins[11:8], 1'b0};
      opLui, opAuipc: return {ins[31:12], 12'b0};
      opJal:          return (s << 20) | {12'b0, ins[19:12], ins[20], ins[30:21], 1'b0};
      default:        return (s << 11) | {21'b0, ins[30:20]};
    endcase
  endfunction

  function automatic logic [31:0] modelRead(input logic [4:0] a);
    if (a == 5'd0) begin
      return '0;
    end
    if (regWriteW && (rdW == a)) begin
      return resultW; // Same-edge writeback
    end
    return mRegs[a];
  endfunction

  // Reference pipeline two edges deep from instrF to the E outputs
  always @(posedge clk) begin
    if (!rstN) begin
      mInstrD <= nopInstr;
      mPcD    <= '0;
      mPc4D   <= '0;
      for (int i = 0; i < 32; i++) begin
        mRegs[i] <= '0;
      end
    end else begin
      if (flushD) begin
        mInstrD <= nopInstr;
        mPcD    <= '0;
        mPc4D   <= '0;
      end else if (!stallD) begin
        mInstrD <= instrF;
        mPcD    <= pcF;
        mPc4D   <= pcPlus4F;
      end
      if (regWriteW && (rdW != 5'd0)) begin
        mRegs[rdW] <= resultW;
      end
    end
    if (!rstN || flushE) begin
      expCtrl <= '0;
      expRs1  <= '0;
      expRs2  <= '0;
      expRd   <= '0;
    end else begin
      expCtrl <= controlsOf(mInstrD);
      expRs1  <= mInstrD[19:15];
      expRs2  <= mInstrD[24:20];
      expRd   <= mInstrD[11:7];
    end
    expRd1 <= modelRead(mInstrD[19:15]);
    expRd2 <= modelRead(mInstrD[24:20]);
    expImm <= signExtImm(mInstrD);
    expPc  <= mPcD;
    expPc4 <= mPc4D;
  end

  valueCheck #(32, "rd1E")        chkRd1 (clk, rstN, rd1E, expRd1, errs[0]);
  valueCheck #(32, "rd2E")        chkRd2 (clk, rstN, rd2E, expRd2, errs[1]);
  valueCheck #(32, "immExtE")     chkImm (clk, rstN, immExtE, expImm, errs[2]);
  valueCheck #(32, "pcE")         chkPc (clk, rstN, pcE, expPc, errs[3]);
  valueCheck #(32, "pcPlus4E")    chkPc4 (clk, rstN, pcPlus4E, expPc4, errs[4]);
  valueCheck #(5, "rs1E")         chkRs1 (clk, rstN, rs1E, expRs1, errs[5]);
  valueCheck #(5, "rs2E")         chkRs2 (clk, rstN, rs2E, expRs2, errs[6]);
  valueCheck #(5, "rdE")          chkRd (clk, rstN, rdE, expRd, errs[7]);
  valueCheck #(1, "regWriteE")    chkRegWr (clk, rstN, regWriteE, expCtrl[14], errs[8]);
  valueCheck #(1, "memWriteE")    chkMemWr (clk, rstN, memWriteE, expCtrl[13], errs[9]);
  valueCheck #(1, "aluSrcE")      chkAluSrc (clk, rstN, aluSrcE, expCtrl[12], errs[10]);
  valueCheck #(1, "branchE")      chkBranch (clk, rstN, branchE, expCtrl[11], errs[11]);
  valueCheck #(1, "jumpE")        chkJump (clk, rstN, jumpE, expCtrl[10], errs[12]);
  valueCheck #(1, "pcResE")       chkPcRes (clk, rstN, pcResE, expCtrl[9], errs[13]);
  valueCheck #(2, "resultSrcE")   chkResSrc (clk, rstN, resultSrcE, expCtrl[8:7], errs[14]);
  valueCheck #(2, "memSizeE")     chkSize (clk, rstN, memSizeE, expCtrl[6:5], errs[15]);
  valueCheck #(1, "memSignedE")   chkSigned (clk, rstN, memSignedE, expCtrl[4], errs[16]);
  valueCheck #(4, "aluControlE")  chkAlu (clk, rstN, aluControlE, expCtrl[3:0], errs[17]);

  resetClearsCtrl: assert property (@(posedge clk) !rstN |=> (dutCtrl == '0))
    else begin
      resetErrs++;
      $display("FAIL time %0t E controls got %h expected 0 after reset", $time,
               $sampled(dutCtrl));
    end

  task automatic nextCycle();
    @(posedge clk);
    #1;
  endtask

  task automatic sendInstr(input logic [31:0] ins);
    instrF   = ins;
    pcF      = pc;
    pcPlus4F = pc + 32'd4;
    pc       = pc + 32'd4;
    vectors++;
    nextCycle();
  endtask

  function automatic logic [31:0] buildRType(input logic [4:0] rs1, input logic [4:0] rs2,
                                             input logic [4:0] rd);
    return {7'b0, rs2, rs1, 3'b000, rd, opR};
  endfunction

  function automatic logic [31:0] randomInstr(input logic [6:0] op);
    logic [31:0] r;
    r = $random(seed);
    return {r[31:7], op};
  endfunction

  // Write lands on the edge that moves the reader from D to E
  task automatic forwardCase(input logic [4:0] r);
    sendInstr(buildRType(r, r, 5'd1));
    regWriteW = 1'b1;
    rdW       = r;
    resultW   = $random(seed);
    sendInstr(nopInstr);
    regWriteW = 1'b0;
  endtask

  initial begin
    repeat (vectorCount * 3 + 100) @(posedge clk);
    $display("Timeout: the run did not finish within the cycle budget");
    $display("Errors found");
    $finish;
  end

  initial begin
    logic [31:0] roll;
    int          total;
    rstN      = 1'b0;
    instrF    = nopInstr;
    pcF       = '0;
    pcPlus4F  = '0;
    stallD    = 1'b0;
    flushD    = 1'b0;
    flushE    = 1'b0;
    regWriteW = 1'b0;
    rdW       = '0;
    resultW   = '0;
    pc        = 32'h0000_1000;
    repeat (4) @(posedge clk);
    #1;
    rstN = 1'b1;

    for (int i = 0; i < resetVectors; i++) begin
      sendInstr(buildRType(5'(i), 5'(31 - i), 5'(i))); // Every address reads zero
    end

    forwardCase(5'd0);
    for (int i = 0; i < writeVectors; i++) begin
      roll = $random(seed);
      if (roll[1:0] == 2'd0) begin
        forwardCase(roll[9:5]);
      end else begin
        regWriteW = 1'b1;
        rdW       = roll[14:10];
        resultW   = $random(seed);
        sendInstr(buildRType(roll[19:15], roll[24:20], roll[29:25]));
      end
    end
    regWriteW = 1'b0;

    foreach (opList[k]) begin
      for (int j = 0; j < decodeVectors; j++) begin
        roll      = $random(seed);
        stallD    = (roll[2:0] == 3'd0);
        flushE    = stallD; // Hazard unit pairs them
        flushD    = (roll[6:3] == 4'd0);
        regWriteW = roll[7];
        rdW       = roll[12:8];
        resultW   = $random(seed);
        sendInstr(randomInstr(opList[k]));
      end
    end
    stallD    = 1'b0;
    flushE    = 1'b0;
    flushD    = 1'b0;
    regWriteW = 1'b0;

    sendInstr(randomInstr(opStore));
    stallD = 1'b1;
    flushE = 1'b1;
    sendInstr(randomInstr(opLoad));
    sendInstr(randomInstr(opLoad));
    stallD = 1'b0;
    flushE = 1'b0;
    sendInstr(randomInstr(opBranch));
    flushD = 1'b1;
    sendInstr(randomInstr(opStore)); // Dropped as a NOP goes on
    stallD = 1'b1;
    sendInstr(randomInstr(opStore)); // Flush still wins
    flushD = 1'b0;
    stallD = 1'b0;
    repeat (4) sendInstr(nopInstr);

    total = resetErrs;
    foreach (errs[i]) begin
      total += errs[i];
    end
    $display("Summary: %0d vectors, %0d value mismatches, %0d reset mismatches", vectors,
             total - resetErrs, resetErrs);
    if (total == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: flist.f
src/rvPkg.sv
src/ctrlBus.sv
src/instrDecoder.sv
src/immExtend.sv
src/regFile.sv
src/decodeStage.sv
src/idExReg.sv
src/decodeTop.sv
bench/decodeTb.sv

// File: run.sh
#!/bin/sh
# Compile and run the decode testbench with Verilator

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert -j 0 --top-module decodeTb -f flist.f -o decodeSim
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

./obj_dir/decodeSim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Errors found" "$log"; then
  exit 1
fi
exit 0

// File: src/ctrlBus.sv
`timescale 1ns/10ps
`default_nettype none

interface ctrlIf;
  import rvPkg::*;

  logic      regWrite;
  logic      memWrite;
  logic      aluSrc;     // ALU operand B from immediate
  logic      branch;
  logic      jump;
  logic      pcRes;      // ALU operand A from PC (auipc)
  resultSrcE resultSrc;
  logic [1:0] memSize;   // Byte, half, word
  logic      memSigned;
  aluCtrlE   aluControl;

  modport dec (output regWrite, memWrite, aluSrc, branch, jump, pcRes,
               resultSrc, memSize, memSigned, aluControl);

  modport stage (input regWrite, memWrite, aluSrc, branch, jump, pcRes,
                 resultSrc, memSize, memSigned, aluControl);

endinterface

`default_nettype wire

// File: src/decodeStage.sv
`timescale 1ns/10ps
`default_nettype none

module decodeStage (
  input  logic          clk,
  input  logic          rstN,
  input  rvPkg::wordT   instrF,
  input  rvPkg::wordT   pcF,
  input  rvPkg::wordT   pcPlus4F,
  input  logic          stallD,
  input  logic          flushD,
  input  logic          regWriteW,
  input  rvPkg::regIdxT rdW,
  input  rvPkg::wordT   resultW,
  ctrlIf.dec            ctrl,
  output rvPkg::wordT   rd1D,
  output rvPkg::wordT   rd2D,
  output rvPkg::wordT   immExtD,
  output rvPkg::wordT   pcD,
  output rvPkg::wordT   pcPlus4D,
  output rvPkg::regIdxT rs1D,
  output rvPkg::regIdxT rs2D,
  output rvPkg::regIdxT rdD
);
  import rvPkg::*;

  wordT   instrD;
  immSrcE immSrcD;
  logic   illegalD;

  // Fetch/decode register where flush beats stall
  always_ff @(posedge clk) begin
    if (!rstN || flushD) begin
      instrD   <= nopInstr;
      pcD      <= '0;
      pcPlus4D <= '0;
    end else if (!stallD) begin
      instrD   <= instrF;
      pcD      <= pcF;
      pcPlus4D <= pcPlus4F;
    end
  end

  assign rs1D = instrD[19:15];
  assign rs2D = instrD[24:20];
  assign rdD  = instrD[11:7];

  instrDecoder uDec (
    .instr   (instrD),
    .ctrl    (ctrl),
    .immSrc  (immSrcD),
    .illegal (illegalD)
  );

  // Reads on rs1/rs2 and writes from writeback
  regFile uRegs (
    .clk  (clk),
    .rstN (rstN),
    .ra1  (rs1D),
    .ra2  (rs2D),
    .wa   (rdW),
    .we   (regWriteW),
    .wd   (resultW),
    .rd1  (rd1D),
    .rd2  (rd2D)
  );

  immExtend uExt (
    .instr  (instrD),
    .immSrc (immSrcD),
    .immExt (immExtD)
  );

  stallHoldsInstr: assert property (@(posedge clk) disable iff (!rstN)
    (stallD && !flushD) |=> $stable(instrD))
    else $error("decodeStage: instrD changed during stall");

  // Fetch should only hand over RV32I opcodes
  noIllegalOpcode: assert property (@(posedge clk) disable iff (!rstN)
    !illegalD)
    else $error("decodeStage: unknown opcode %b in decode", instrD[6:0]);

endmodule

`default_nettype wire

// File: src/decodeTop.sv
`timescale 1ns/10ps
`default_nettype none

module decodeTop (
  input  logic           clk,
  input  logic           rstN,
  input  rvPkg::wordT    instrF,
  input  rvPkg::wordT    pcF,
  input  rvPkg::wordT    pcPlus4F,
  input  logic           stallD,
  input  logic           flushD,
  input  logic           flushE,
  input  logic           regWriteW,
  input  rvPkg::regIdxT  rdW,
  input  rvPkg::wordT    resultW,
  output rvPkg::wordT    rd1E,
  output rvPkg::wordT    rd2E,
  output rvPkg::wordT    immExtE,
  output rvPkg::wordT    pcE,
  output rvPkg::wordT    pcPlus4E,
  output rvPkg::regIdxT  rs1E,
  output rvPkg::regIdxT  rs2E,
  output rvPkg::regIdxT  rdE,
  output logic           regWriteE,
  output logic           memWriteE,
  output logic           aluSrcE,
  output logic           branchE,
  output logic           jumpE,
  output logic           pcResE,
  output logic [1:0]     resultSrcE,
  output logic [1:0]     memSizeE,
  output logic           memSignedE,
  output rvPkg::aluCtrlE aluControlE
);
  import rvPkg::*;

  wordT   rd1D;
  wordT   rd2D;
  wordT   immExtD;
  wordT   pcD;
  wordT   pcPlus4D;
  regIdxT rs1D;
  regIdxT rs2D;
  regIdxT rdD;

  ctrlIf ctrlD (); // Decoded controls from D to E

  decodeStage uStage (
    .clk       (clk),
    .rstN      (rstN),
    .instrF    (instrF),
    .pcF       (pcF),
    .pcPlus4F  (pcPlus4F),
    .stallD    (stallD),
    .flushD    (flushD),
    .regWriteW (regWriteW),
    .rdW       (rdW),
    .resultW   (resultW),
    .ctrl      (ctrlD.dec),
    .rd1D      (rd1D),
    .rd2D      (rd2D),
    .immExtD   (immExtD),
    .pcD       (pcD),
    .pcPlus4D  (pcPlus4D),
    .rs1D      (rs1D),
    .rs2D      (rs2D),
    .rdD       (rdD)
  );

  idExReg uIdEx (
    .clk         (clk),
    .rstN        (rstN),
    .flushE      (flushE),
    .ctrl        (ctrlD.stage),
    .rd1D        (rd1D),
    .rd2D        (rd2D),
    .immExtD     (immExtD),
    .pcD         (pcD),
    .pcPlus4D    (pcPlus4D),
    .rs1D        (rs1D),
    .rs2D        (rs2D),
    .rdD         (rdD),
    .rd1E        (rd1E),
    .rd2E        (rd2E),
    .immExtE     (immExtE),
    .pcE         (pcE),
    .pcPlus4E    (pcPlus4E),
    .rs1E        (rs1E),
    .rs2E        (rs2E),
    .rdE         (rdE),
    .regWriteE   (regWriteE),
    .memWriteE   (memWriteE),
    .aluSrcE     (aluSrcE),
    .branchE     (branchE),
    .jumpE       (jumpE),
    .pcResE      (pcResE),
    .resultSrcE  (resultSrcE),
    .memSizeE    (memSizeE),
    .memSignedE  (memSignedE),
    .aluControlE (aluControlE)
  );

endmodule

`default_nettype wire

// File: src/idExReg.sv
`timescale 1ns/10ps
`default_nettype none

module idExReg (
  input  logic           clk,
  input  logic           rstN,
  input  logic           flushE,
  ctrlIf.stage           ctrl,
  input  rvPkg::wordT    rd1D,
  input  rvPkg::wordT    rd2D,
  input  rvPkg::wordT    immExtD,
  input  rvPkg::wordT    pcD,
  input  rvPkg::wordT    pcPlus4D,
  input  rvPkg::regIdxT  rs1D,
  input  rvPkg::regIdxT  rs2D,
  input  rvPkg::regIdxT  rdD,
  output rvPkg::wordT    rd1E,
  output rvPkg::wordT    rd2E,
  output rvPkg::wordT    immExtE,
  output rvPkg::wordT    pcE,
  output rvPkg::wordT    pcPlus4E,
  output rvPkg::regIdxT  rs1E,
  output rvPkg::regIdxT  rs2E,
  output rvPkg::regIdxT  rdE,
  output logic           regWriteE,
  output logic           memWriteE,
  output logic           aluSrcE,
  output logic           branchE,
  output logic           jumpE,
  output logic           pcResE,
  output logic [1:0]     resultSrcE,
  output logic [1:0]     memSizeE,
  output logic           memSignedE,
  output rvPkg::aluCtrlE aluControlE
);
  import rvPkg::*;

  // Control and indices zeroed for a bubble
  always_ff @(posedge clk) begin
    if (!rstN || flushE) begin
      regWriteE   <= 1'b0;
      memWriteE   <= 1'b0;
      aluSrcE     <= 1'b0;
      branchE     <= 1'b0;
      jumpE       <= 1'b0;
      pcResE      <= 1'b0;
      resultSrcE  <= 2'b00;
      memSizeE    <= 2'b00;
      memSignedE  <= 1'b0;
      aluControlE <= aluAdd;
      rs1E        <= '0;
      rs2E        <= '0;
      rdE         <= '0;
    end else begin
      regWriteE   <= ctrl.regWrite;
      memWriteE   <= ctrl.memWrite;
      aluSrcE     <= ctrl.aluSrc;
      branchE     <= ctrl.branch;
      jumpE       <= ctrl.jump;
      pcResE      <= ctrl.pcRes;
      resultSrcE  <= ctrl.resultSrc;
      memSizeE    <= ctrl.memSize;
      memSignedE  <= ctrl.memSigned;
      aluControlE <= ctrl.aluControl;
      rs1E        <= rs1D;
      rs2E        <= rs2D;
      rdE         <= rdD;
    end
  end

  // Operands, immediate and PCs
  always_ff @(posedge clk) begin
    rd1E     <= rd1D;
    rd2E     <= rd2D;
    immExtE  <= immExtD;
    pcE      <= pcD;
    pcPlus4E <= pcPlus4D;
  end

endmodule

`default_nettype wire

// File: src/immExtend.sv
`timescale 1ns/10ps
`default_nettype none

module immExtend (
  input  rvPkg::wordT   instr,
  input  rvPkg::immSrcE immSrc,
  output rvPkg::wordT   immExt
);
  import rvPkg::*;

  logic sign; // Bit 31 is the sign in every format

  assign sign = instr[31];

  always_comb begin
    case (immSrc)
      immI: begin
        immExt = {{20{sign}}, instr[31:20]};
      end
      immS: begin
        immExt = {{20{sign}}, instr[31:25], instr[11:7]};
      end
      immB: begin
        // Halfword offset with bit 0 implied zero
        immExt = {{20{sign}}, instr[7], instr[30:25], instr[11:8], 1'b0};
      end
      immU: begin
        immExt = {instr[31:12], 12'b0}; // Upper 20 bits already in place
      end
      immJ: begin
        immExt = {{12{sign}}, instr[19:12], instr[20], instr[30:21], 1'b0};
      end
      default: begin
        immExt = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: src/instrDecoder.sv
`timescale 1ns/10ps
`default_nettype none

module instrDecoder (
  input  rvPkg::wordT   instr,
  ctrlIf.dec            ctrl,
  output rvPkg::immSrcE immSrc,
  output logic          illegal
);
  import rvPkg::*;

  opcodeE     opcode;
  logic [2:0] funct3;
  logic       funct7b5;
  logic [1:0] aluOp;     // 00 add, 01 branch compare, 10 funct decode
  logic       regWrite;
  logic       memWrite;
  logic       aluSrc;
  logic       branch;
  logic       jump;
  logic       pcRes;
  resultSrcE  resultSrc;
  logic [1:0] memSize;
  logic       memSigned;
  aluCtrlE    aluControl;

  assign opcode   = opcodeE'(instr[6:0]);
  assign funct3   = instr[14:12];
  assign funct7b5 = instr[30];

  // Main decoder
  always_comb begin
    regWrite  = 1'b0;
    memWrite  = 1'b0;
    aluSrc    = 1'b0;
    branch    = 1'b0;
    jump      = 1'b0;
    pcRes     = 1'b0;
    resultSrc = resAlu;
    memSize   = 2'b00;
    memSigned = 1'b0;
    immSrc    = immI;
    aluOp     = 2'b00;
    illegal   = 1'b0;
    case (opcode)
      opR: begin
        regWrite = 1'b1;
        aluOp    = 2'b10;
      end
      opI: begin
        regWrite = 1'b1;
        aluSrc   = 1'b1;
        aluOp    = 2'b10;
      end
      opLoad: begin
        regWrite  = 1'b1;
        aluSrc    = 1'b1;
        resultSrc = resMem;
        memSize   = funct3[1:0];
        memSigned = !funct3[2]; // lbu/lhu clear bit
      end
      opStore: begin
        memWrite = 1'b1;
        aluSrc   = 1'b1;
        immSrc   = immS;
        memSize  = funct3[1:0];
      end
      opBranch: begin
        branch = 1'b1;
        immSrc = immB;
        aluOp  = 2'b01;
      end
      opJal: begin
        regWrite  = 1'b1;
        jump      = 1'b1;
        immSrc    = immJ;
        resultSrc = resPc4;
      end
      opJalr: begin
        regWrite  = 1'b1;
        jump      = 1'b1;
        aluSrc    = 1'b1;
        resultSrc = resPc4; // Target is rs1 + imm from ALU
      end
      opLui: begin
        regWrite = 1'b1;
        aluSrc   = 1'b1;
        immSrc   = immU;
      end
      opAuipc: begin
        regWrite = 1'b1;
        aluSrc   = 1'b1;
        pcRes    = 1'b1;
        immSrc   = immU;
      end
      default: illegal = 1'b1; // Controls stay zero
    endcase
    assert (!(memWrite && regWrite))
      else $error("instrDecoder: memWrite and regWrite both set, opcode %b", instr[6:0]);
  end

  // ALU decoder
  always_comb begin
    aluControl = aluAdd;
    case (aluOp)
      2'b01: begin
        case (funct3[2:1])
          2'b10:   aluControl = aluSlt;  // blt, bge
          2'b11:   aluControl = aluSltu; // bltu, bgeu
          default: aluControl = aluSub;  // beq, bne
        endcase
      end
      2'b10: begin
        case (funct3)
          3'b000:  aluControl = (funct7b5 && instr[5]) ? aluSub : aluAdd; // addi never subtracts
          3'b001:  aluControl = aluSll;
          3'b010:  aluControl = aluSlt;
          3'b011:  aluControl = aluSltu;
          3'b100:  aluControl = aluXor;
          3'b101:  aluControl = funct7b5 ? aluSra : aluSrl;
          3'b110:  aluControl = aluOr;
          default: aluControl = aluAnd;
        endcase
      end
      default: aluControl = aluAdd;
    endcase
  end

  assign ctrl.regWrite   = regWrite;
  assign ctrl.memWrite   = memWrite;
  assign ctrl.aluSrc     = aluSrc;
  assign ctrl.branch     = branch;
  assign ctrl.jump       = jump;
  assign ctrl.pcRes      = pcRes;
  assign ctrl.resultSrc  = resultSrc;
  assign ctrl.memSize    = memSize;
  assign ctrl.memSigned  = memSigned;
  assign ctrl.aluControl = aluControl;

endmodule

`default_nettype wire

// File: src/regFile.sv
`timescale 1ns/10ps
`default_nettype none

module regFile (
  input  logic          clk,
  input  logic          rstN,
  input  rvPkg::regIdxT ra1,
  input  rvPkg::regIdxT ra2,
  input  rvPkg::regIdxT wa,
  input  logic          we,
  input  rvPkg::wordT   wd,
  output rvPkg::wordT   rd1,
  output rvPkg::wordT   rd2
);
  import rvPkg::*;

  wordT regs [regCount];
  logic wrEn; // Write qualified against x0

  assign wrEn = we && (wa != '0);

  always_ff @(posedge clk) begin
    if (!rstN) begin
      for (int i = 0; i < regCount; i++) begin
        regs[i] <= '0;
      end
    end else if (wrEn) begin
      regs[wa] <= wd;
    end
  end

  // Write-through so decode sees writeback in the same cycle
  always_comb begin
    if (ra1 == '0) begin
      rd1 = '0;
    end else if (wrEn && (wa == ra1)) begin
      rd1 = wd;
    end else begin
      rd1 = regs[ra1];
    end
  end

  always_comb begin
    if (ra2 == '0) begin
      rd2 = '0;
    end else if (wrEn && (wa == ra2)) begin
      rd2 = wd;
    end else begin
      rd2 = regs[ra2];
    end
  end

  x0ReadsZero: assert property (@(posedge clk) disable iff (!rstN)
    (ra1 == '0) |-> (rd1 == '0))
    else $error("regFile: x0 read returned %h", rd1);

endmodule

`default_nettype wire

// File: src/rvPkg.sv
`default_nettype none

package rvPkg;

  typedef logic [31:0] wordT;   // Data or address word
  typedef logic [4:0]  regIdxT; // Register file index

  // RV32I major opcodes handled by the decoder
  typedef enum logic [6:0] {
    opR      = 7'b0110011,
    opI      = 7'b0010011,
    opLoad   = 7'b0000011,
    opStore  = 7'b0100011,
    opBranch = 7'b1100011,
    opJal    = 7'b1101111,
    opJalr   = 7'b1100111,
    opLui    = 7'b0110111,
    opAuipc  = 7'b0010111
  } opcodeE;

  typedef enum logic [3:0] {
    aluAdd  = 4'd0, // Zero code doubles as bubble value
    aluSub  = 4'd1,
    aluAnd  = 4'd2,
    aluOr   = 4'd3,
    aluXor  = 4'd4,
    aluSll  = 4'd5,
    aluSrl  = 4'd6,
    aluSra  = 4'd7,
    aluSlt  = 4'd8,
    aluSltu = 4'd9
  } aluCtrlE;

  typedef enum logic [2:0] {
    immI = 3'd0,
    immS = 3'd1,
    immB = 3'd2,
    immU = 3'd3,
    immJ = 3'd4
  } immSrcE;

  typedef enum logic [1:0] {
    resAlu = 2'd0,
    resMem = 2'd1,
    resPc4 = 2'd2 // Link value for jal/jalr
  } resultSrcE;

  localparam wordT nopInstr = 32'h0000_0013; // addi x0, x0, 0
  localparam int   regCount = 32;

endpackage

`default_nettype wire
